//--- cache_subsystem.f
+incdir+.
cache_pkg.sv
access_queue.sv
mshr_table.sv
cache_bank.sv
bus_arbiter.sv
cache_subsystem.sv
cache_subsystem_chk.sv
tb_cache_subsystem.sv

//--- Makefile
# Verilator build and run for the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
FILELIST  ?= cache_subsystem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := cache_macros.svh cache_pkg.sv access_queue.sv mshr_table.sv cache_bank.sv \
        bus_arbiter.sv cache_subsystem.sv cache_subsystem_chk.sv tb_cache_subsystem.sv
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_REQ = 400;
  localparam int WINDOW_LINES = 64;
  localparam int LINES = 2048;
  localparam cache_pkg::line_addr_t WINDOW_BASE = 11'h1c0;

  logic clk;
  logic rst_n;
  logic req_valid;
  logic req_ready;
  logic req_write;
  cache_pkg::req_id_t req_id;
  cache_pkg::paddr_t req_addr;
  cache_pkg::word_t req_wdata;
  logic resp_valid;
  cache_pkg::req_id_t resp_id;
  cache_pkg::word_t resp_rdata;
  logic bus_valid;
  logic bus_write;
  cache_pkg::line_addr_t bus_addr;
  cache_pkg::line_t bus_wdata;
  logic bus_ready;
  logic fill_valid;
  cache_pkg::line_addr_t fill_addr;
  cache_pkg::line_t fill_data;

  // Memory image and the word-level reference copy
  cache_pkg::line_t mem_line [LINES];
  cache_pkg::word_t ref_word [LINES*4];

  // Accepted bus reads, answered in order
  cache_pkg::line_addr_t rd_addr_q [$];
  cache_pkg::line_t rd_data_q [$];
  int rd_due_q [$];

  logic [15:0] in_flight;
  cache_pkg::word_t exp_rdata [16];
  int n_in_flight;
  int issued;
  int cycle;
  int last_due;
  bit solo;
  cache_pkg::req_id_t solo_id;
  cache_pkg::paddr_t warm_addr;

  cache_subsystem dut (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
    .req_id(req_id), .req_addr(req_addr), .req_wdata(req_wdata),
    .resp_valid(resp_valid), .resp_id(resp_id), .resp_rdata(resp_rdata),
    .bus_valid(bus_valid), .bus_write(bus_write), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_ready(bus_ready),
    .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  // Odd multiplier keeps every word address distinct
  function automatic cache_pkg::word_t init_word(input logic [12:0] word_addr);
    return (32'(word_addr) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input cache_pkg::req_id_t got,
                          input cache_pkg::req_id_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
    end
  endtask

  function automatic cache_pkg::paddr_t pick_addr();
    cache_pkg::line_addr_t line;
    logic [1:0] word;
    line = WINDOW_BASE + cache_pkg::line_addr_t'($urandom % WINDOW_LINES);
    word = 2'($urandom);
    return {line, word, 2'b00};
  endfunction

  function automatic cache_pkg::req_id_t pick_free_id();
    cache_pkg::req_id_t pool [$];
    for (int i = 0; i < 16; i++) begin
      if (!in_flight[i]) begin
        pool.push_back(4'(i));
      end
    end
    return pool[$urandom % pool.size()];
  endfunction

  task automatic take_response();
    cache_pkg::req_id_t id;
    if (resp_valid) begin
      id = resp_id;
      // Only one access outstanding, so the id is known
      if (solo) begin
        check_id("resp_id", id, solo_id);
      end
      if (!in_flight[id]) begin
        abort_run($sformatf("Got a response for id %0d, which is not in flight", id));
      end
      check_word("resp_rdata", resp_rdata, exp_rdata[id]);
      in_flight[id] = 1'b0;
      n_in_flight--;
    end
  endtask

  task automatic serve_memory();
    int due;
    fill_valid = 1'b0;
    if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle) begin
      fill_valid = 1'b1;
      fill_addr = rd_addr_q.pop_front();
      fill_data = rd_data_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    bus_ready = ($urandom % 4) != 0;
    // bus_valid only moves on a rising edge, so this transfer is certain
    if (bus_valid && bus_ready) begin
      if (bus_write) begin
        mem_line[bus_addr] = bus_wdata;
      end else begin
        due = cycle + 2 + int'($urandom % 11);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rd_addr_q.push_back(bus_addr);
        rd_data_q.push_back(mem_line[bus_addr]);
        rd_due_q.push_back(due);
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);
    cycle++;
    if (dut.u_chk.fail_count != 0) begin
      abort_run("A bus, fill queue or MSHR assertion failed");
    end
    req_valid = 1'b0;
    take_response();
    serve_memory();
  endtask

  // Caller makes sure req_ready is high, so the request is taken at the next rising edge
  task automatic send(input logic write, input cache_pkg::paddr_t addr,
                      input cache_pkg::word_t data, input cache_pkg::req_id_t id);
    logic [12:0] wa;
    wa = addr[14:2];
    req_valid = 1'b1;
    req_write = write;
    req_id = id;
    req_addr = addr;
    req_wdata = data;
    if (write) begin
      ref_word[wa] = data;
      exp_rdata[id] = '0;
    end else begin
      exp_rdata[id] = ref_word[wa];
    end
    in_flight[id] = 1'b1;
    n_in_flight++;
    issued++;
  endtask

  initial begin
    void'($urandom(32'h3de5_0d38));
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_id = '0;
    req_addr = '0;
    req_wdata = '0;
    bus_ready = 1'b0;
    fill_valid = 1'b0;
    fill_addr = '0;
    fill_data = '0;
    in_flight = '0;
    n_in_flight = 0;
    issued = 0;
    cycle = 0;
    last_due = 0;
    solo = 1'b0;
    solo_id = '0;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < 4; w++) begin
        mem_line[l][w*32 +: 32] = init_word({11'(l), 2'(w)});
        ref_word[l*4 + w] = init_word({11'(l), 2'(w)});
      end
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    tick();
    check_bit("req_ready", req_ready, 1'b1);
    check_bit("resp_valid", resp_valid, 1'b0);
    check_bit("bus_valid", bus_valid, 1'b0);

    // Warm-up with a single write, then a read of the same word
    solo = 1'b1;
    warm_addr = pick_addr();
    solo_id = 4'd9;
    send(1'b1, warm_addr, $urandom, solo_id);
    while (n_in_flight != 0) begin
      tick();
    end
    tick();
    solo_id = 4'd6;
    send(1'b0, warm_addr, '0, solo_id);
    while (n_in_flight != 0) begin
      tick();
    end
    solo = 1'b0;

    // Random traffic, roughly 40 percent writes
    while (issued < NUM_REQ || n_in_flight != 0) begin
      tick();
      if (issued < NUM_REQ && req_ready && n_in_flight < 16 && ($urandom % 4) != 0) begin
        send(($urandom % 10) < 4, pick_addr(), $urandom, pick_free_id());
      end
    end

    // Idle tail catches stray or duplicate responses
    repeat (20) begin
      tick();
    end
    if (in_flight == '0 && issued == NUM_REQ) begin
      $display("Test OK");
      $finish;
    end else begin
      abort_run("Requests are still in flight at the end of the run");
    end
  end

  initial begin
    #(NUM_REQ * 200 * CLK_PERIOD);
    abort_run("Watchdog expired before all requests completed");
  end

endmodule

//--- cache_subsystem_chk.sv
`timescale 1ns/1ps

module cache_subsystem_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   bus_valid,
  input logic                   bus_ready,
  input logic                   bus_write,
  input cache_pkg::line_addr_t  bus_addr,
  input cache_pkg::line_t       bus_wdata,
  input logic                   fq_push,
  input logic                   fq_full,
  input logic                   alloc,
  input logic                   mshr_full,
  input logic                   dealloc,
  input logic                   fq_pop
);

  // Failed assertions, read by the testbench
  int fail_count = 0;

  // Stalled bus request keeps its payload
  a_bus_stable: assert property (@(posedge clk) disable iff (!rst_n)
      bus_valid && !bus_ready |=> bus_valid && $stable(bus_write) &&
      $stable(bus_addr) && $stable(bus_wdata))
    else begin
      fail_count++;
      $error("bus payload changed while bus_ready was low");
    end

  a_fq_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      !(fq_push && fq_full))
    else begin
      fail_count++;
      $error("fill pushed into a full fill queue");
    end

  a_alloc_not_full: assert property (@(posedge clk) disable iff (!rst_n)
      alloc |-> !mshr_full)
    else begin
      fail_count++;
      $error("MSHR alloc while the table is full");
    end

  // Entry is freed only by the fill that is installed
  a_dealloc_with_pop: assert property (@(posedge clk) disable iff (!rst_n)
      dealloc |-> fq_pop)
    else begin
      fail_count++;
      $error("MSHR dealloc without a fill queue pop");
    end

endmodule

bind cache_subsystem cache_subsystem_chk u_chk (
  .clk(clk), .rst_n(rst_n),
  .bus_valid(bus_valid), .bus_ready(bus_ready), .bus_write(bus_write),
  .bus_addr(bus_addr), .bus_wdata(bus_wdata),
  .fq_push(fq_push), .fq_full(fq_full),
  .alloc(alloc), .mshr_full(mshr_full),
  .dealloc(dealloc), .fq_pop(fq_pop)
);

//--- cache_subsystem.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_subsystem (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core side
  input  logic                   req_valid,
  output logic                   req_ready,
  input  logic                   req_write,
  input  cache_pkg::req_id_t     req_id,
  input  cache_pkg::paddr_t      req_addr,
  input  cache_pkg::word_t       req_wdata,
  output logic                   resp_valid,
  output cache_pkg::req_id_t     resp_id,
  output cache_pkg::word_t       resp_rdata,
  // Memory side
  output logic                   bus_valid,
  output logic                   bus_write,
  output cache_pkg::line_addr_t  bus_addr,
  output cache_pkg::line_t       bus_wdata,
  input  logic                   bus_ready,
  input  logic                   fill_valid,
  input  cache_pkg::line_addr_t  fill_addr,
  input  cache_pkg::line_t       fill_data
);

  cache_pkg::req_t aq_in;
  cache_pkg::req_t aq_head;
  logic aq_push;
  logic aq_full;
  logic aq_empty;
  logic aq_pop;
  cache_pkg::fill_t fq_in;
  cache_pkg::fill_t fq_head;
  logic fq_push;
  logic fq_full;
  logic fq_empty;
  logic fq_pop;
  cache_pkg::line_addr_t lookup_line;
  cache_pkg::line_addr_t fill_line;
  cache_pkg::req_t alloc_req;
  cache_pkg::req_t fill_req;
  logic mshr_hit;
  logic mshr_full;
  logic alloc;
  logic dealloc;
  logic wb_valid;
  logic wb_full;
  cache_pkg::line_addr_t wb_addr;
  cache_pkg::line_t wb_data;
  logic rd_valid;
  logic rd_full;
  cache_pkg::line_addr_t rd_addr;

  // Pack the loose core and memory ports for the queues
  always_comb begin
    aq_in.id = req_id;
    aq_in.write = req_write;
    aq_in.paddr = req_addr;
    aq_in.wdata = req_wdata;
    fq_in.addr = fill_addr;
    fq_in.data = fill_data;
  end

  assign req_ready = !aq_full;
  assign aq_push = req_valid && req_ready;
  assign fq_push = fill_valid;

  access_queue #(.payload_t(cache_pkg::req_t), .DEPTH(`AQ_DEPTH)) u_aq (
    .clk(clk), .rst_n(rst_n), .push(aq_push), .push_data(aq_in), .full(aq_full),
    .pop(aq_pop), .head(aq_head), .empty(aq_empty)
  );

  access_queue #(.payload_t(cache_pkg::fill_t), .DEPTH(`FQ_DEPTH)) u_fq (
    .clk(clk), .rst_n(rst_n), .push(fq_push), .push_data(fq_in), .full(fq_full),
    .pop(fq_pop), .head(fq_head), .empty(fq_empty)
  );

  cache_bank u_bank (
    .clk(clk), .rst_n(rst_n),
    .aq_head(aq_head), .aq_empty(aq_empty), .aq_pop(aq_pop),
    .fq_head(fq_head), .fq_empty(fq_empty), .fq_pop(fq_pop),
    .lookup_line(lookup_line), .mshr_hit(mshr_hit), .mshr_full(mshr_full),
    .alloc(alloc), .alloc_req(alloc_req),
    .fill_line(fill_line), .fill_req(fill_req), .dealloc(dealloc),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_full(wb_full),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_full(rd_full),
    .resp_valid(resp_valid), .resp_id(resp_id), .resp_rdata(resp_rdata)
  );

  mshr_table u_mshr (
    .clk(clk), .rst_n(rst_n),
    .lookup_line(lookup_line), .mshr_hit(mshr_hit), .mshr_full(mshr_full),
    .alloc(alloc), .alloc_req(alloc_req),
    .fill_line(fill_line), .fill_req(fill_req), .dealloc(dealloc)
  );

  bus_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_full(wb_full),
    .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_full(rd_full),
    .bus_valid(bus_valid), .bus_write(bus_write), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_ready(bus_ready)
  );

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_valid,
  input  cache_pkg::line_addr_t  wb_addr,
  input  cache_pkg::line_t       wb_data,
  output logic                   wb_full,
  input  logic                   rd_valid,
  input  cache_pkg::line_addr_t  rd_addr,
  output logic                   rd_full,
  output logic                   bus_valid,
  output logic                   bus_write,
  output cache_pkg::line_addr_t  bus_addr,
  output cache_pkg::line_t       bus_wdata,
  input  logic                   bus_ready
);

  cache_pkg::line_addr_t wb_addr_q;
  cache_pkg::line_t wb_data_q;
  cache_pkg::line_addr_t rd_addr_q;
  logic wb_done;
  logic rd_done;

  // Writeback goes out first
  assign bus_valid = wb_full || rd_full;
  assign bus_write = wb_full;
  assign bus_addr = wb_full ? wb_addr_q : rd_addr_q;
  assign bus_wdata = wb_full ? wb_data_q : '0;

  assign wb_done = wb_full && bus_ready;
  assign rd_done = !wb_full && rd_full && bus_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_full <= 1'b0;
      rd_full <= 1'b0;
    end else begin
      if (wb_valid && !wb_full) begin
        wb_full <= 1'b1;
      end else if (wb_done) begin
        wb_full <= 1'b0;
      end
      if (rd_valid && !rd_full) begin
        rd_full <= 1'b1;
      end else if (rd_done) begin
        rd_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid && !wb_full) begin
      wb_addr_q <= wb_addr;
      wb_data_q <= wb_data;
    end
    if (rd_valid && !rd_full) begin
      rd_addr_q <= rd_addr;
    end
  end

endmodule

//--- cache_bank.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_bank (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::req_t        aq_head,
  input  logic                   aq_empty,
  output logic                   aq_pop,
  input  cache_pkg::fill_t       fq_head,
  input  logic                   fq_empty,
  output logic                   fq_pop,
  output cache_pkg::line_addr_t  lookup_line,
  input  logic                   mshr_hit,
  input  logic                   mshr_full,
  output logic                   alloc,
  output cache_pkg::req_t        alloc_req,
  output cache_pkg::line_addr_t  fill_line,
  input  cache_pkg::req_t        fill_req,
  output logic                   dealloc,
  output logic                   wb_valid,
  output cache_pkg::line_addr_t  wb_addr,
  output cache_pkg::line_t       wb_data,
  input  logic                   wb_full,
  output logic                   rd_valid,
  output cache_pkg::line_addr_t  rd_addr,
  input  logic                   rd_full,
  output logic                   resp_valid,
  output cache_pkg::req_id_t     resp_id,
  output cache_pkg::word_t       resp_rdata
);

  localparam int WAYS = `CACHE_WAYS;
  localparam int SETS = `CACHE_SETS;
  localparam int WAY_W = $clog2(WAYS);
  localparam int SET_W = cache_pkg::INDEX_W;
  localparam int OFS_W = cache_pkg::OFFSET_W;

  // State arrays
  logic [WAYS-1:0] valid_q [SETS];
  logic [WAYS-1:0] dirty_q [SETS];
  logic [WAY_W-1:0] age_q [SETS][WAYS];
  cache_pkg::tag_t tag_q [SETS][WAYS];
  cache_pkg::line_t data_q [SETS][WAYS];

  logic stall;
  logic do_fill;
  logic do_acc;
  logic do_hit;
  logic do_miss;
  logic upd;
  logic [SET_W-1:0] acc_set;
  cache_pkg::tag_t acc_tag;
  logic [SET_W-1:0] fill_set;
  cache_pkg::tag_t fill_tag;
  logic hit;
  logic [WAY_W-1:0] hit_way;
  logic vic_found;
  logic [WAY_W-1:0] vic_way;
  logic [SET_W-1:0] upd_set;
  logic [WAY_W-1:0] upd_way;
  cache_pkg::req_t upd_req;
  logic [OFS_W-3:0] upd_word;
  cache_pkg::line_t base_line;
  cache_pkg::line_t new_line;
  cache_pkg::word_t rd_word;

  assign acc_set = aq_head.paddr[OFS_W +: SET_W];
  assign acc_tag = aq_head.paddr[`PADDR_W-1 -: cache_pkg::TAG_W];
  assign fill_set = fq_head.addr[SET_W-1:0];
  assign fill_tag = fq_head.addr[$bits(cache_pkg::line_addr_t)-1:SET_W];

  // Nothing starts while either bus holding register is occupied
  assign stall = wb_full || rd_full;
  // Fills take priority over new accesses
  assign do_fill = !fq_empty && !stall;
  assign do_acc = fq_empty && !aq_empty && !stall && !mshr_hit;
  assign do_hit = do_acc && hit;
  assign do_miss = do_acc && !hit && !mshr_full;
  assign upd = do_fill || do_hit;

  // Tag compare for the access head
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (valid_q[acc_set][w] && (tag_q[acc_set][w] == acc_tag)) begin
        hit = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // Victim: first invalid way, else the oldest one
  always_comb begin
    vic_found = 1'b0;
    vic_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (!valid_q[fill_set][w] && !vic_found) begin
        vic_found = 1'b1;
        vic_way = WAY_W'(w);
      end
    end
    if (!vic_found) begin
      for (int w = 0; w < WAYS; w++) begin
        if (age_q[fill_set][w] == '1) begin
          vic_way = WAY_W'(w);
        end
      end
    end
  end

  // Shared datapath for hit and fill install
  always_comb begin
    upd_set = do_fill ? fill_set : acc_set;
    upd_way = do_fill ? vic_way : hit_way;
    upd_req = do_fill ? fill_req : aq_head;
    upd_word = upd_req.paddr[OFS_W-1:2];
    base_line = do_fill ? fq_head.data : data_q[acc_set][hit_way];
    rd_word = base_line[upd_word*32 +: 32];
    new_line = base_line;
    if (upd_req.write) begin
      new_line[upd_word*32 +: 32] = upd_req.wdata;
    end
  end

  assign aq_pop = do_hit || do_miss;
  assign fq_pop = do_fill;

  assign lookup_line = aq_head.paddr[`PADDR_W-1:OFS_W];
  assign alloc = do_miss;
  assign alloc_req = aq_head;
  assign rd_valid = do_miss;
  assign rd_addr = lookup_line;

  assign fill_line = fq_head.addr;
  assign dealloc = do_fill;

  // Dirty victim leaves on the writeback channel
  assign wb_valid = do_fill && valid_q[fill_set][vic_way] && dirty_q[fill_set][vic_way];
  assign wb_addr = {tag_q[fill_set][vic_way], fill_set};
  assign wb_data = data_q[fill_set][vic_way];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < WAYS; w++) begin
          age_q[s][w] <= WAY_W'(w);
        end
      end
    end else begin
      resp_valid <= upd;
      if (upd) begin
        valid_q[upd_set][upd_way] <= 1'b1;
        if (do_fill) begin
          dirty_q[upd_set][upd_way] <= upd_req.write;
        end else if (upd_req.write) begin
          dirty_q[upd_set][upd_way] <= 1'b1;
        end
        // Touched way becomes youngest, younger ones age by one
        for (int w = 0; w < WAYS; w++) begin
          if (WAY_W'(w) == upd_way) begin
            age_q[upd_set][w] <= '0;
          end else if (age_q[upd_set][w] < age_q[upd_set][upd_way]) begin
            age_q[upd_set][w] <= age_q[upd_set][w] + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (upd) begin
      data_q[upd_set][upd_way] <= new_line;
      resp_id <= upd_req.id;
      // Writes are acknowledged with zero data
      resp_rdata <= upd_req.write ? '0 : rd_word;
    end
    if (do_fill) begin
      tag_q[upd_set][upd_way] <= fill_tag;
    end
  end

endmodule

//--- mshr_table.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module mshr_table (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::line_addr_t  lookup_line,
  output logic                   mshr_hit,
  output logic                   mshr_full,
  input  logic                   alloc,
  input  cache_pkg::req_t        alloc_req,
  input  cache_pkg::line_addr_t  fill_line,
  output cache_pkg::req_t        fill_req,
  input  logic                   dealloc
);

  localparam int N = `MSHR_ENTRIES;
  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [N-1:0] valid_q;
  cache_pkg::req_t req_q [N];
  logic [N-1:0] look_match;
  logic [N-1:0] fill_match;
  logic [IDX_W-1:0] free_idx;

  // Line address of each parked request
  function automatic cache_pkg::line_addr_t entry_line(cache_pkg::req_t r);
    return r.paddr[`PADDR_W-1:cache_pkg::OFFSET_W];
  endfunction

  always_comb begin
    for (int i = 0; i < N; i++) begin
      look_match[i] = valid_q[i] && (entry_line(req_q[i]) == lookup_line);
      fill_match[i] = valid_q[i] && (entry_line(req_q[i]) == fill_line);
    end
  end

  assign mshr_hit = |look_match;
  assign mshr_full = &valid_q;

  // Parked request for the returning line
  always_comb begin
    fill_req = '0;
    for (int i = 0; i < N; i++) begin
      if (fill_match[i]) begin
        fill_req = req_q[i];
      end
    end
  end

  // Lowest free entry wins
  always_comb begin
    free_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (dealloc) begin
        valid_q <= valid_q & ~fill_match;
      end
      if (alloc && !mshr_full) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc && !mshr_full) begin
      req_q[free_idx] <= alloc_req;
    end
  end

endmodule

//--- access_queue.sv
`timescale 1ns/1ps

module access_queue #(
  parameter type payload_t = logic,
  parameter int DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t head,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  logic do_push;
  logic do_pop;

  assign full = (count == (PTR_W+1)'(DEPTH));
  assign empty = (count == '0);
  // Head is visible while the entry sits in the buffer
  assign head = mem[rd_ptr];

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  // Address split: offset, set index, tag
  localparam int OFFSET_W = $clog2(`LINE_BYTES);
  localparam int INDEX_W = $clog2(`CACHE_SETS);
  localparam int TAG_W = `PADDR_W - INDEX_W - OFFSET_W;

  typedef logic [`PADDR_W-1:0] paddr_t;
  typedef logic [`PADDR_W-OFFSET_W-1:0] line_addr_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [31:0] word_t;
  typedef logic [`LINE_BYTES*8-1:0] line_t;
  typedef logic [3:0] req_id_t;

  // One core access, read or full-word write
  typedef struct packed {
    req_id_t id;
    logic    write;
    paddr_t  paddr;
    word_t   wdata;
  } req_t;

  // Line returned by memory
  typedef struct packed {
    line_addr_t addr;
    line_t      data;
  } fill_t;

endpackage

//--- cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 4
`define LINE_BYTES 16

// Physical byte address width
`define PADDR_W 15

// Outstanding misses and queue sizing
`define MSHR_ENTRIES 2
`define AQ_DEPTH 4

// One slot per outstanding miss, so fills never overflow
`define FQ_DEPTH `MSHR_ENTRIES

`endif
